//--- Bender.yml
package:
  name: clct_sorter

sources:
  # synthesizable design
  - target: rtl
    include_dirs:
      - .
    files:
      - clct_pkg.sv
      - clct_frame_receiver.sv
      - best_1of7_cclut.sv
      - clct_result_sender.sv
      - clct_sorter_top.sv

  # simulation only
  - target: test
    include_dirs:
      - .
    files:
      - clct_sorter_assertions.sv
      - tb_clct_sorter.sv

//--- best_1of7_cclut.sv
`timescale 1ns/1ps
`default_nettype none

`include "clct_config.svh"

module best_1of7_cclut
  import clct_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         frame_valid,
  input  clct_frame_t  frame,
  output logic         frame_take,
  output logic         res_valid,
  output clct_result_t res,
  input  logic         res_take
);

  logic [`CLCT_GRPB-1:0]    win_grp;
  clct_cand_t               win;
  logic [`CLCT_KEYXB-1:0]   key_x;
  logic [`CLCT_SUBKEYB-1:0] subkey;
  logic                     qual;
  logic                     load;

  // ------------------------------------------------------------
  // best 1 of 7 on the full pattern number
  // ------------------------------------------------------------

  // a later group must beat the running best strictly,
  // so ties stay with the lowest group index
  always_comb
  begin
    win_grp = '0;
    for (int g = 1; g < `CLCT_NGROUPS; g++)
    begin
      if (frame[g].pat > frame[win_grp].pat)
        win_grp = g[`CLCT_GRPB-1:0];
    end
  end

  assign win = frame[win_grp];

  // ------------------------------------------------------------
  // chamber key and quarter-strip subkey
  // ------------------------------------------------------------

  always_comb
  begin
    // group index on top of the group key, then the coarse offset
    // correction from the ccLUT offset code, all modulo 256
    key_x = {win_grp, win.key}
          + {{(`CLCT_KEYXB-2){1'b0}}, win.offs[3:2]}
          + {{(`CLCT_KEYXB-1){1'b0}}, win.offs[1] & win.offs[0]}
          - `CLCT_KEYXB'd2;
    // two fine bits below the key, wrap within 2 bits
    subkey = {key_x, win.offs[1:0] + 2'd1};
  end

  // hit count lives in the upper pattern bits
  assign qual = (win.pat[`CLCT_PATB-1:`CLCT_PATB-`CLCT_HITB] >= `CLCT_MIN_HITS);

  // ------------------------------------------------------------
  // result register with back-pressure
  // ------------------------------------------------------------

  // load when the slot is empty or is being drained right now
  assign load       = frame_valid && (!res_valid || res_take);
  assign frame_take = load;

  always_ff @(posedge clock)
  begin
    if (reset)
      res_valid <= 1'b0;
    else if (load)
      res_valid <= 1'b1;
    else if (res_take)
      res_valid <= 1'b0;
  end

  // held as long as the sender does not take it
  always_ff @(posedge clock)
  begin
    if (load)
    begin
      res.best_pat    <= win.pat;
      res.best_key    <= key_x;
      res.best_bend   <= win.bend;
      res.best_carry  <= win.carry;
      res.best_subkey <= subkey;
      res.best_group  <= win_grp;
      res.quality_ok  <= qual;
    end
  end

endmodule

`default_nettype wire

//--- clct_config.svh
`ifndef CLCT_CONFIG_SVH
`define CLCT_CONFIG_SVH

// ------------------------------------------------------------
// chamber geometry
// ------------------------------------------------------------

// half-strip groups scanned by the pattern finder
`define CLCT_NGROUPS   7
// bits needed to name one group
`define CLCT_GRPB      3

// ------------------------------------------------------------
// candidate fields
// ------------------------------------------------------------

// pattern number, hit count on top, pattern id below
`define CLCT_PATB      7
// hit count part of the pattern number
`define CLCT_HITB      3
// key half-strip inside a group
`define CLCT_KEYB      5
// position offset code from the ccLUT
`define CLCT_OFFSB     4
// bend code
`define CLCT_BNDB      5
// comparator code
`define CLCT_CARRYB    12

// ------------------------------------------------------------
// results
// ------------------------------------------------------------

// chamber key half-strip, group index on top of group key
`define CLCT_KEYXB     8
// quarter-strip subkey, chamber key plus two fine bits
`define CLCT_SUBKEYB   10
// fewest layers hit for a good pattern
`define CLCT_MIN_HITS  4

`endif

//--- clct_frame_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module clct_frame_receiver
  import clct_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        in_req,
  input  clct_frame_t in_frame,
  output logic        in_ack,
  output logic        frame_valid,
  output clct_frame_t frame,
  input  logic        frame_take
);

  hs_state_t state;
  logic      capture;

  // take a new frame only when idle and the holding register is free
  // the source keeps in_frame stable while in_req is high
  assign capture = (state == HS_IDLE) && in_req && !frame_valid;

  // ------------------------------------------------------------
  // request/acknowledge sequencing
  // ------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state  <= HS_IDLE;
      in_ack <= 1'b0;
    end
    else
    begin
      case (state)
        HS_IDLE:
        begin
          if (capture)
            state <= HS_REQ;
        end
        HS_REQ:
        begin
          // frame is safely held, tell the source
          in_ack <= 1'b1;
          state  <= HS_WAIT_LOW;
        end
        HS_WAIT_LOW:
        begin
          // release once the source has dropped its request
          if (!in_req)
          begin
            in_ack <= 1'b0;
            state  <= HS_IDLE;
          end
        end
        default:
        begin
          in_ack <= 1'b0;
          state  <= HS_IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // frame holding register
  // ------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (reset)
      frame_valid <= 1'b0;
    else if (capture)
      frame_valid <= 1'b1;
    else if (frame_take)
      frame_valid <= 1'b0;
  end

  // payload only, qualified by frame_valid
  always_ff @(posedge clock)
  begin
    if (capture)
      frame <= in_frame;
  end

endmodule

`default_nettype wire

//--- clct_pkg.sv
`default_nettype none

`include "clct_config.svh"

package clct_pkg;

  // ------------------------------------------------------------
  // one half-strip group candidate from the pattern finder
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`CLCT_PATB-1:0]   pat;
    logic [`CLCT_KEYB-1:0]   key;
    logic [`CLCT_OFFSB-1:0]  offs;
    logic [`CLCT_BNDB-1:0]   bend;
    logic [`CLCT_CARRYB-1:0] carry;
  } clct_cand_t;

  // full event, group 0 sits in the low bits
  typedef clct_cand_t [`CLCT_NGROUPS-1:0] clct_frame_t;

  // ------------------------------------------------------------
  // best-pattern result handed downstream
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`CLCT_PATB-1:0]    best_pat;
    logic [`CLCT_KEYXB-1:0]   best_key;
    logic [`CLCT_BNDB-1:0]    best_bend;
    logic [`CLCT_CARRYB-1:0]  best_carry;
    logic [`CLCT_SUBKEYB-1:0] best_subkey;
    logic [`CLCT_GRPB-1:0]    best_group;
    // winner has enough layers hit
    logic                     quality_ok;
  } clct_result_t;

  // four-phase handshake states, shared by both ends
  typedef enum logic [1:0] {
    // waiting for work
    HS_IDLE,
    // request phase in progress
    HS_REQ,
    // waiting for the other side to drop its line
    HS_WAIT_LOW
  } hs_state_t;

endpackage

`default_nettype wire

//--- clct_result_sender.sv
`timescale 1ns/1ps
`default_nettype none

module clct_result_sender
  import clct_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         res_valid,
  input  clct_result_t res,
  output logic         res_take,
  output logic         out_req,
  output clct_result_t out_result,
  input  logic         out_ack
);

  // two entries, pointers carry an extra wrap bit
  clct_result_t mem [2];
  logic [1:0]   wr_ptr;
  logic [1:0]   rd_ptr;
  logic         full;
  logic         empty;
  logic         retire;
  hs_state_t    state;

  // ------------------------------------------------------------
  // result queue
  // ------------------------------------------------------------

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[1] != rd_ptr[1]) && (wr_ptr[0] == rd_ptr[0]);

  assign res_take = res_valid && !full;

  always_ff @(posedge clock)
  begin
    if (res_take)
      mem[wr_ptr[0]] <= res;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (res_take)
        wr_ptr <= wr_ptr + 2'd1;
      if (retire)
        rd_ptr <= rd_ptr + 2'd1;
    end
  end

  // head entry is never overwritten while it is being sent
  assign out_result = mem[rd_ptr[0]];

  // ------------------------------------------------------------
  // four-phase output
  // ------------------------------------------------------------

  // head leaves the queue only after the sink has released ack
  assign retire = (state == HS_WAIT_LOW) && !out_ack;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state   <= HS_IDLE;
      out_req <= 1'b0;
    end
    else
    begin
      case (state)
        HS_IDLE:
        begin
          if (!empty)
          begin
            out_req <= 1'b1;
            state   <= HS_REQ;
          end
        end
        HS_REQ:
        begin
          if (out_ack)
          begin
            out_req <= 1'b0;
            state   <= HS_WAIT_LOW;
          end
        end
        HS_WAIT_LOW:
        begin
          if (!out_ack)
            state <= HS_IDLE;
        end
        default:
        begin
          out_req <= 1'b0;
          state   <= HS_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- clct_sorter_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module clct_sorter_assertions
  import clct_pkg::*;
(
  input logic         clock,
  input logic         reset,
  input logic         in_req,
  input logic         in_ack,
  input logic         out_req,
  input logic         out_ack,
  input clct_result_t out_result
);

  // running count of assertion failures
  int assert_errors = 0;

  // ------------------------------------------------------------
  // input side
  // ------------------------------------------------------------

  // ack may only answer a live request
  ack_follows_req: assert property (@(posedge clock) disable iff (reset)
    $rose(in_ack) |-> in_req)
  else
  begin
    assert_errors++;
    $error("in_ack rose while in_req was low");
  end

  // ------------------------------------------------------------
  // output side
  // ------------------------------------------------------------

  // request is held until the sink answers
  req_held: assert property (@(posedge clock) disable iff (reset)
    (out_req && !out_ack) |=> out_req)
  else
  begin
    assert_errors++;
    $error("out_req dropped before out_ack rose");
  end

  // payload frozen for the whole request phase
  result_stable: assert property (@(posedge clock) disable iff (reset)
    (out_req && $past(out_req)) |-> $stable(out_result))
  else
  begin
    assert_errors++;
    $error("out_result changed while out_req was high");
  end

  // both handshakes come out of reset idle
  idle_after_reset: assert property (@(posedge clock)
    reset |=> (!in_ack && !out_req))
  else
  begin
    assert_errors++;
    $error("in_ack or out_req high right after reset");
  end

endmodule

bind clct_sorter_top clct_sorter_assertions u_assert (
  .clock      (clock),
  .reset      (reset),
  .in_req     (in_req),
  .in_ack     (in_ack),
  .out_req    (out_req),
  .out_ack    (out_ack),
  .out_result (out_result)
);

`default_nettype wire

//--- clct_sorter_top.sv
`timescale 1ns/1ps
`default_nettype none

module clct_sorter_top
  import clct_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         in_req,
  input  clct_frame_t  in_frame,
  output logic         in_ack,
  output logic         out_req,
  output clct_result_t out_result,
  input  logic         out_ack
);

  // ------------------------------------------------------------
  // internal valid/take links
  // ------------------------------------------------------------
  logic         frame_valid;
  clct_frame_t  frame;
  logic         frame_take;
  logic         res_valid;
  clct_result_t res;
  logic         res_take;

  // input side, one frame deep
  clct_frame_receiver u_receiver (
    .clock       (clock),
    .reset       (reset),
    .in_req      (in_req),
    .in_frame    (in_frame),
    .in_ack      (in_ack),
    .frame_valid (frame_valid),
    .frame       (frame),
    .frame_take  (frame_take)
  );

  // best pattern, one result register
  best_1of7_cclut u_best (
    .clock       (clock),
    .reset       (reset),
    .frame_valid (frame_valid),
    .frame       (frame),
    .frame_take  (frame_take),
    .res_valid   (res_valid),
    .res         (res),
    .res_take    (res_take)
  );

  // output side, two-entry queue
  clct_result_sender u_sender (
    .clock      (clock),
    .reset      (reset),
    .res_valid  (res_valid),
    .res        (res),
    .res_take   (res_take),
    .out_req    (out_req),
    .out_result (out_result),
    .out_ack    (out_ack)
  );

endmodule

`default_nettype wire

//--- tb_clct_sorter.sv
`timescale 1ns/1ps
`default_nettype none

`include "clct_config.svh"

module tb_clct_sorter
  import clct_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  // frames per test, in test order
  localparam int FRAMES_TOTAL = 1 + 2 + 20 + 2 + 8 + 40;
  localparam int CYCLES_PER_FRAME = 200;

  logic         clock = 1'b0;
  logic         reset;
  logic         in_req;
  clct_frame_t  in_frame;
  logic         in_ack;
  logic         out_req;
  clct_result_t out_result;
  logic         out_ack;

  // expected results in send order, and what the sink received
  clct_result_t exp_q[$];
  clct_result_t got_q[$];
  int           sink_delay = 0;
  logic [31:0]  lcg_state = 32'd24;
  int           errors = 0;
  int           errors_at_start = 0;
  int           tests_passed = 0;
  int           tests_failed = 0;

  clct_sorter_top u_dut (
    .clock      (clock),
    .reset      (reset),
    .in_req     (in_req),
    .in_frame   (in_frame),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_result (out_result),
    .out_ack    (out_ack)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // ------------------------------------------------------------
  // reference model and stimulus helpers
  // ------------------------------------------------------------

  function automatic clct_result_t model_result(input clct_frame_t f);
    clct_result_t r;
    clct_cand_t   c;
    int           top_pat;
    int           grp;
    int           key_sum;
    int           fine;
    top_pat = 0;
    for (int g = 0; g < `CLCT_NGROUPS; g++)
    begin
      if (int'(f[g].pat) > top_pat)
        top_pat = int'(f[g].pat);
    end
    // lowest group holding the top pattern
    grp = `CLCT_NGROUPS - 1;
    for (int g = `CLCT_NGROUPS - 1; g >= 0; g--)
    begin
      if (int'(f[g].pat) == top_pat)
        grp = g;
    end
    c = f[grp];
    key_sum = grp * (1 << `CLCT_KEYB) + int'(c.key) + int'(c.offs[3:2])
            + int'(c.offs[1] & c.offs[0]) - 2;
    // wrap into the 8-bit chamber key, negative sums included
    key_sum = (key_sum + (1 << `CLCT_KEYXB)) % (1 << `CLCT_KEYXB);
    fine = (int'(c.offs[1:0]) + 1) % 4;
    r.best_pat    = c.pat;
    r.best_key    = key_sum[`CLCT_KEYXB-1:0];
    r.best_bend   = c.bend;
    r.best_carry  = c.carry;
    r.best_subkey = {key_sum[`CLCT_KEYXB-1:0], fine[1:0]};
    r.best_group  = grp[`CLCT_GRPB-1:0];
    r.quality_ok  = (int'(c.pat) >> (`CLCT_PATB - `CLCT_HITB)) >= `CLCT_MIN_HITS;
    return r;
  endfunction

  function automatic clct_cand_t make_cand(input int pat, input int key, input int offs,
                                           input int bend, input int carry);
    clct_cand_t c;
    c.pat   = pat[`CLCT_PATB-1:0];
    c.key   = key[`CLCT_KEYB-1:0];
    c.offs  = offs[`CLCT_OFFSB-1:0];
    c.bend  = bend[`CLCT_BNDB-1:0];
    c.carry = carry[`CLCT_CARRYB-1:0];
    return c;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic clct_frame_t random_frame();
    clct_frame_t f;
    logic [63:0] bits;
    for (int g = 0; g < `CLCT_NGROUPS; g++)
    begin
      bits[63:32] = lcg_next();
      bits[31:0]  = lcg_next();
      // upper bits of the generator are the better mixed ones
      f[g] = bits[63:31];
    end
    return f;
  endfunction

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  task automatic compare_result(input string name, input clct_result_t expected,
                                input clct_result_t actual);
    if (actual !== expected)
    begin
      errors++;
      $display("Fail time %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      errors++;
      $display("Fail time %0t: %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic wait_results(input int n);
    while (got_q.size() < n)
      @(posedge clock);
  endtask

  // drain both queues in order, then one summary line for the test
  task automatic check_results(input string test_name);
    clct_result_t expected;
    clct_result_t actual;
    wait_results(exp_q.size());
    while (exp_q.size() > 0)
    begin
      expected = exp_q.pop_front();
      actual   = got_q.pop_front();
      compare_result("out_result", expected, actual);
    end
    if (got_q.size() != 0)
    begin
      errors++;
      $display("test %s received more results than frames were sent", test_name);
      got_q.delete();
    end
    if (errors == errors_at_start)
      tests_passed++;
    else
      tests_failed++;
    $display("test %s finished with %0d errors", test_name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  // ------------------------------------------------------------
  // source and sink
  // ------------------------------------------------------------

  // four-phase source, entered and left on a rising edge
  task automatic send_frame(input clct_frame_t f);
    exp_q.push_back(model_result(f));
    in_frame <= f;
    in_req   <= 1'b1;
    do
      @(posedge clock);
    while (!in_ack);
    in_req <= 1'b0;
    do
      @(posedge clock);
    while (in_ack);
  endtask

  // four-phase sink with a programmable ack delay
  initial
  begin
    out_ack <= 1'b0;
    forever
    begin
      @(posedge clock);
      if (out_req && !out_ack)
      begin
        got_q.push_back(out_result);
        repeat (sink_delay) @(posedge clock);
        out_ack <= 1'b1;
        do
          @(posedge clock);
        while (out_req);
        out_ack <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------

  task automatic test_distinct();
    clct_frame_t f;
    int          pats[7] = '{12, 40, 27, 63, 108, 51, 33};
    for (int g = 0; g < `CLCT_NGROUPS; g++)
      f[g] = make_cand(pats[g], 3 * g + 1, g, g + 7, 100 * g + 5);
    send_frame(f);
    check_results("distinct");
  endtask

  task automatic test_ties();
    clct_frame_t f;
    // top pattern shared by groups 2, 5 and 6
    for (int g = 0; g < `CLCT_NGROUPS; g++)
      f[g] = make_cand((g == 2 || g == 5 || g == 6) ? 85 : 20 + g, 4 + g, 5, g, 11 * g);
    send_frame(f);
    // all seven equal
    for (int g = 0; g < `CLCT_NGROUPS; g++)
      f[g] = make_cand(51, 31 - g, g + 1, 2 * g, 300 + g);
    send_frame(f);
    check_results("ties");
  endtask

  task automatic test_key_math();
    clct_frame_t f;
    int          offs_list[5] = '{0, 3, 7, 12, 15};
    int          grps[2] = '{0, 6};
    int          keys[2] = '{0, 31};
    for (int gi = 0; gi < 2; gi++)
    begin
      for (int ki = 0; ki < 2; ki++)
      begin
        for (int oi = 0; oi < 5; oi++)
        begin
          f = '0;
          f[grps[gi]] = make_cand(74, keys[ki], offs_list[oi], 9, 2748);
          send_frame(f);
        end
      end
    end
    check_results("key_math");
  endtask

  task automatic test_quality();
    clct_frame_t f;
    f = '0;
    // three layers hit
    f[3] = make_cand(63, 10, 6, 4, 1);
    send_frame(f);
    wait_results(1);
    compare_flag("quality_ok", 1'b0, got_q[0].quality_ok);
    // four layers hit
    f[3] = make_cand(64, 10, 6, 4, 1);
    send_frame(f);
    wait_results(2);
    compare_flag("quality_ok", 1'b1, got_q[1].quality_ok);
    check_results("quality");
  endtask

  task automatic test_backpressure();
    sink_delay = 12;
    for (int i = 0; i < 8; i++)
      send_frame(random_frame());
    check_results("backpressure");
    sink_delay = 0;
  endtask

  task automatic test_random();
    for (int i = 0; i < 40; i++)
    begin
      sink_delay = int'(lcg_next() >> 30);
      send_frame(random_frame());
    end
    check_results("random");
    sink_delay = 0;
  endtask

  // ------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------

  initial
  begin
    reset    <= 1'b1;
    in_req   <= 1'b0;
    in_frame <= '0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    test_distinct();
    test_ties();
    test_key_math();
    test_quality();
    test_backpressure();
    test_random();
    errors = errors + u_dut.u_assert.assert_errors;
    $display("tests passed %0d failed %0d, assertion failures %0d",
             tests_passed, tests_failed, u_dut.u_assert.assert_errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // budget grows with the number of frames sent
  initial
  begin
    #(FRAMES_TOTAL * CYCLES_PER_FRAME * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, a handshake hung",
             FRAMES_TOTAL * CYCLES_PER_FRAME);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
clct_pkg.sv
clct_frame_receiver.sv
best_1of7_cclut.sv
clct_result_sender.sv
clct_sorter_top.sv
clct_sorter_assertions.sv
tb_clct_sorter.sv
